/* logic/seg_pkg.sv */
package seg_pkg;

    localparam int NUM_SEGS = 7;

    // Segment index from A=0 up to G=6
    typedef logic [2:0] seg_idx_t;

    // Bit i belongs to segment i
    typedef logic [NUM_SEGS-1:0] seg_mask_t;

    typedef enum logic [1:0] {
        RIGHT = 2'd0,
        LEFT  = 2'd1,
        UP    = 2'd2,
        DOWN  = 2'd3
    } dir_t;

    localparam seg_idx_t SEG_A = 3'd0;
    localparam seg_idx_t SEG_B = 3'd1;
    localparam seg_idx_t SEG_C = 3'd2;
    localparam seg_idx_t SEG_D = 3'd3;
    localparam seg_idx_t SEG_E = 3'd4;
    localparam seg_idx_t SEG_F = 3'd5;
    localparam seg_idx_t SEG_G = 3'd6;

    // One step of the snake for a single button press
    // Returns 0 when the press leads nowhere from here
    function automatic logic walk_step(
        input  seg_idx_t seg,
        input  dir_t     head,
        input  dir_t     btn,
        output seg_idx_t next_seg,
        output dir_t     next_head
    );
        logic       ok;
        logic [4:0] nxt;
        ok  = 1'b1;
        nxt = {seg, head};
        case ({seg, head, btn})
            {SEG_A, RIGHT, RIGHT}: nxt = {SEG_B, DOWN};
            {SEG_A, LEFT, LEFT}:   nxt = {SEG_F, DOWN};
            {SEG_B, UP, LEFT}:     nxt = {SEG_A, LEFT};
            {SEG_B, DOWN, RIGHT}:  nxt = {SEG_G, LEFT};
            {SEG_B, DOWN, UP}:     nxt = {SEG_C, DOWN};
            {SEG_C, UP, LEFT}:     nxt = {SEG_G, LEFT};
            {SEG_C, UP, UP}:       nxt = {SEG_B, UP};
            {SEG_C, DOWN, RIGHT}:  nxt = {SEG_D, DOWN};
            {SEG_D, RIGHT, LEFT}:  nxt = {SEG_C, UP};
            {SEG_D, LEFT, RIGHT}:  nxt = {SEG_E, UP};
            {SEG_E, UP, RIGHT}:    nxt = {SEG_G, RIGHT};
            {SEG_E, UP, UP}:       nxt = {SEG_F, UP};
            {SEG_E, DOWN, LEFT}:   nxt = {SEG_D, RIGHT};
            {SEG_F, UP, RIGHT}:    nxt = {SEG_A, RIGHT};
            {SEG_F, DOWN, LEFT}:   nxt = {SEG_G, RIGHT};
            {SEG_G, RIGHT, LEFT}:  nxt = {SEG_B, UP};
            {SEG_G, RIGHT, RIGHT}: nxt = {SEG_C, DOWN};
            {SEG_G, LEFT, LEFT}:   nxt = {SEG_E, DOWN};
            {SEG_G, LEFT, RIGHT}:  nxt = {SEG_F, UP};
            default:               ok = 1'b0;
        endcase
        next_seg  = nxt[4:2];
        next_head = dir_t'(nxt[1:0]);
        return ok;
    endfunction

endpackage

/* logic/game_pkg.sv */
package game_pkg;

    typedef enum logic [1:0] {
        PH_INIT = 2'd0,
        PH_MOVE = 2'd1,
        PH_FALL = 2'd2
    } phase_t;

    // Consecutive high samples that make a press
    localparam int DEBOUNCE_DEPTH = 4;

    // One-second ticks spent on the idle digit
    localparam int INIT_SECONDS = 3;

    localparam int SEC_CNT_W = $clog2(INIT_SECONDS + 1);

    typedef logic [SEC_CNT_W-1:0] sec_cnt_t;

endpackage

/* logic/button_pulse.sv */
module button_pulse (
    input  logic clk,
    input  logic rst,
    input  logic button,
    output logic pulse
);

    logic [game_pkg::DEBOUNCE_DEPTH-1:0] samples;
    logic                                level;
    logic                                level_q;

    // Pressed only once the whole sample window is high
    assign level = &samples;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            samples <= '0;
            level_q <= 1'b0;
            pulse   <= 1'b0;
        end else begin
            samples <= {samples[game_pkg::DEBOUNCE_DEPTH-2:0], button};
            level_q <= level;
            // Rising edge of the clean level
            pulse   <= level & ~level_q;
        end
    end

endmodule

/* logic/tick_gen.sv */
module tick_gen #(
    parameter int tick_cycles = 50_000_000
) (
    input  logic clk,
    input  logic rst,
    output logic half_tick,
    output logic sec_tick
);

    logic [$clog2(tick_cycles)-1:0] cnt;
    logic                           odd_half;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt       <= '0;
            odd_half  <= 1'b0;
            half_tick <= 1'b0;
            sec_tick  <= 1'b0;
        end else if (int'(cnt) == tick_cycles - 1) begin
            cnt       <= '0;
            odd_half  <= ~odd_half;
            half_tick <= 1'b1;
            // Second half of each pair closes a full second
            sec_tick  <= odd_half;
        end else begin
            cnt       <= cnt + 1'b1;
            half_tick <= 1'b0;
            sec_tick  <= 1'b0;
        end
    end

endmodule

/* logic/game_fsm.sv */
module game_fsm (
    input  logic             clk,
    input  logic             rst,
    input  logic             sec_tick,
    input  logic             half_tick,
    input  logic             down_pulse,
    input  logic             trail_full,
    output game_pkg::phase_t phase
);

    game_pkg::phase_t   phase_next;
    game_pkg::sec_cnt_t secs;

    always_comb begin
        phase_next = phase;
        case (phase)
            game_pkg::PH_INIT: begin
                if (secs == game_pkg::sec_cnt_t'(game_pkg::INIT_SECONDS)) begin
                    phase_next = game_pkg::PH_MOVE;
                end
            end
            game_pkg::PH_MOVE: begin
                if (down_pulse) begin
                    phase_next = game_pkg::PH_FALL;
                end
            end
            game_pkg::PH_FALL: begin
                // Back to idle on the half tick after the digit fills
                if (half_tick && trail_full) begin
                    phase_next = game_pkg::PH_INIT;
                end
            end
            default: begin
                phase_next = game_pkg::PH_INIT;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase <= game_pkg::PH_INIT;
        end else begin
            phase <= phase_next;
        end
    end

    // Seconds only count while idling
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            secs <= '0;
        end else if (phase_next != game_pkg::PH_INIT) begin
            secs <= '0;
        end else if (sec_tick) begin
            secs <= secs + 1'b1;
        end
    end

    phase_legal_a: assert property (
        @(posedge clk) disable iff (rst)
        phase inside {game_pkg::PH_INIT, game_pkg::PH_MOVE, game_pkg::PH_FALL}
    );

endmodule

/* logic/segment_walker.sv */
module segment_walker (
    input  logic              clk,
    input  logic              rst,
    input  game_pkg::phase_t  phase,
    input  logic              right_pulse,
    input  logic              left_pulse,
    input  logic              up_pulse,
    output seg_pkg::seg_idx_t cursor,
    output seg_pkg::dir_t     heading
);

    seg_pkg::dir_t     btn;
    logic              pressed;
    logic              step_ok;
    seg_pkg::seg_idx_t step_seg;
    seg_pkg::dir_t     step_head;

    assign pressed = right_pulse | left_pulse | up_pulse;

    // Right wins over left, and left over up
    always_comb begin
        if (right_pulse) begin
            btn = seg_pkg::RIGHT;
        end else if (left_pulse) begin
            btn = seg_pkg::LEFT;
        end else begin
            btn = seg_pkg::UP;
        end
    end

    always_comb begin
        step_ok = seg_pkg::walk_step(cursor, heading, btn, step_seg, step_head);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cursor  <= seg_pkg::SEG_G;
            heading <= seg_pkg::LEFT;
        end else if (phase == game_pkg::PH_INIT) begin
            // Every game starts on G heading left
            cursor  <= seg_pkg::SEG_G;
            heading <= seg_pkg::LEFT;
        end else if (pressed && step_ok) begin
            cursor  <= step_seg;
            heading <= step_head;
        end
    end

    cursor_range_a: assert property (
        @(posedge clk) disable iff (rst)
        cursor <= seg_pkg::SEG_G
    );

endmodule

/* logic/trail_display.sv */
module trail_display (
    input  logic               clk,
    input  logic               rst,
    input  game_pkg::phase_t   phase,
    input  seg_pkg::seg_idx_t  cursor,
    input  logic               half_tick,
    output seg_pkg::seg_mask_t segments,
    output logic               trail_full
);

    seg_pkg::seg_mask_t cur_mask;
    seg_pkg::seg_mask_t visited;
    seg_pkg::seg_mask_t visited_next;
    seg_pkg::seg_mask_t lit;
    logic               in_fall;
    logic               blink;

    assign in_fall      = (phase == game_pkg::PH_FALL);
    assign cur_mask     = seg_pkg::seg_mask_t'(1) << cursor;
    assign visited_next = visited | cur_mask;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            visited    <= '0;
            blink      <= 1'b0;
            trail_full <= 1'b0;
        end else if (!in_fall) begin
            visited    <= '0;
            blink      <= 1'b0;
            trail_full <= 1'b0;
        end else begin
            visited    <= visited_next;
            blink      <= blink ^ half_tick;
            // Drops with the half tick that ends the fall
            trail_full <= &visited_next & ~half_tick;
        end
    end

    always_comb begin
        case (phase)
            game_pkg::PH_MOVE: lit = cur_mask;
            game_pkg::PH_FALL: lit = visited_next ^ (blink ? cur_mask : '0);
            default:           lit = seg_pkg::seg_mask_t'(1) << seg_pkg::SEG_G;
        endcase
    end

    // Panel segments light on a low level
    assign segments = ~lit;

    full_in_fall_a: assert property (
        @(posedge clk) disable iff (rst)
        trail_full |-> phase == game_pkg::PH_FALL
    );

endmodule

/* logic/snake_top.sv */
module snake_top #(
    // Half a second at 100 MHz
    parameter int tick_cycles = 50_000_000
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               right,
    input  logic               left,
    input  logic               up,
    input  logic               down,
    output seg_pkg::seg_mask_t segments,
    output logic               init,
    output logic               move,
    output logic               fall,
    output seg_pkg::dir_t      heading
);

    logic              right_pulse;
    logic              left_pulse;
    logic              up_pulse;
    logic              down_pulse;
    logic              half_tick;
    logic              sec_tick;
    logic              trail_full;
    game_pkg::phase_t  phase;
    seg_pkg::seg_idx_t cursor;

    button_pulse right_btn_inst (.clk(clk), .rst(rst), .button(right), .pulse(right_pulse));
    button_pulse left_btn_inst  (.clk(clk), .rst(rst), .button(left),  .pulse(left_pulse));
    button_pulse up_btn_inst    (.clk(clk), .rst(rst), .button(up),    .pulse(up_pulse));
    button_pulse down_btn_inst  (.clk(clk), .rst(rst), .button(down),  .pulse(down_pulse));

    tick_gen #(
        .tick_cycles(tick_cycles)
    ) tick_gen_inst (
        .clk      (clk),
        .rst      (rst),
        .half_tick(half_tick),
        .sec_tick (sec_tick)
    );

    game_fsm game_fsm_inst (
        .clk       (clk),
        .rst       (rst),
        .sec_tick  (sec_tick),
        .half_tick (half_tick),
        .down_pulse(down_pulse),
        .trail_full(trail_full),
        .phase     (phase)
    );

    segment_walker segment_walker_inst (
        .clk        (clk),
        .rst        (rst),
        .phase      (phase),
        .right_pulse(right_pulse),
        .left_pulse (left_pulse),
        .up_pulse   (up_pulse),
        .cursor     (cursor),
        .heading    (heading)
    );

    trail_display trail_display_inst (
        .clk       (clk),
        .rst       (rst),
        .phase     (phase),
        .cursor    (cursor),
        .half_tick (half_tick),
        .segments  (segments),
        .trail_full(trail_full)
    );

    // Phase flags for the board LEDs
    assign init = (phase == game_pkg::PH_INIT);
    assign move = (phase == game_pkg::PH_MOVE);
    assign fall = (phase == game_pkg::PH_FALL);

endmodule

/* tests/snake_tb.sv */
module snake_tb;

    localparam int TICK_CYCLES = 20;
    localparam int HOLD        = game_pkg::DEBOUNCE_DEPTH + 4;
    localparam int SHORT       = game_pkg::DEBOUNCE_DEPTH - 1;
    localparam int MOVE_LIMIT  = (game_pkg::INIT_SECONDS + 1) * 2 * TICK_CYCLES + 4;
    localparam int NUM_PRESSES = 40;

    localparam seg_pkg::seg_mask_t G_ONLY = ~(seg_pkg::seg_mask_t'(1) << seg_pkg::SEG_G);

    logic               clk;
    logic               rst;
    logic               right;
    logic               left;
    logic               up;
    logic               down;
    seg_pkg::seg_mask_t segments;
    logic               init;
    logic               move;
    logic               fall;
    seg_pkg::dir_t      heading;

    int                 errors;
    int                 cyc;
    logic [31:0]        rng;
    logic               stepping;
    logic               fall_model;
    logic               quiet_prev;
    logic               cursor_bit_prev;
    seg_pkg::seg_idx_t  model_seg;
    seg_pkg::dir_t      model_head;
    seg_pkg::seg_mask_t visited;

    // Indexed by {segment, heading, button}, holds {valid, segment, heading}
    logic [5:0]         walk_tab [0:127];

    snake_top #(
        .tick_cycles(TICK_CYCLES)
    ) snake_top_inst (
        .clk     (clk),
        .rst     (rst),
        .right   (right),
        .left    (left),
        .up      (up),
        .down    (down),
        .segments(segments),
        .init    (init),
        .move    (move),
        .fall    (fall),
        .heading (heading)
    );

    always #5 clk = ~clk;

    // Same count as the tick divider, which starts with the first edge out of reset
    always @(posedge clk) begin
        if (rst) begin
            cyc <= 0;
        end else begin
            cyc <= cyc + 1;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic seg_pkg::seg_mask_t lit_mask(input seg_pkg::seg_idx_t seg);
        return seg_pkg::seg_mask_t'(1) << seg;
    endfunction

    // Active low pattern with a single segment lit
    function automatic seg_pkg::seg_mask_t dark_except(input seg_pkg::seg_idx_t seg);
        seg_pkg::seg_mask_t m;
        m = seg_pkg::seg_mask_t'(1) << seg;
        return ~m;
    endfunction

    function automatic logic phase_flag(input game_pkg::phase_t which);
        case (which)
            game_pkg::PH_INIT: return init;
            game_pkg::PH_MOVE: return move;
            default:           return fall;
        endcase
    endfunction

    task automatic add_edge(input seg_pkg::seg_idx_t seg, input seg_pkg::dir_t head,
                            input seg_pkg::dir_t btn, input seg_pkg::seg_idx_t nseg,
                            input seg_pkg::dir_t nhead);
        walk_tab[{seg, head, btn}] = {1'b1, nseg, nhead};
    endtask

    task automatic load_walk_table();
        for (int k = 0; k < 128; k++) begin
            walk_tab[k] = '0;
        end
        add_edge(seg_pkg::SEG_A, seg_pkg::RIGHT, seg_pkg::RIGHT, seg_pkg::SEG_B, seg_pkg::DOWN);
        add_edge(seg_pkg::SEG_A, seg_pkg::LEFT,  seg_pkg::LEFT,  seg_pkg::SEG_F, seg_pkg::DOWN);
        add_edge(seg_pkg::SEG_B, seg_pkg::UP,    seg_pkg::LEFT,  seg_pkg::SEG_A, seg_pkg::LEFT);
        add_edge(seg_pkg::SEG_B, seg_pkg::DOWN,  seg_pkg::RIGHT, seg_pkg::SEG_G, seg_pkg::LEFT);
        add_edge(seg_pkg::SEG_B, seg_pkg::DOWN,  seg_pkg::UP,    seg_pkg::SEG_C, seg_pkg::DOWN);
        add_edge(seg_pkg::SEG_C, seg_pkg::UP,    seg_pkg::LEFT,  seg_pkg::SEG_G, seg_pkg::LEFT);
        add_edge(seg_pkg::SEG_C, seg_pkg::UP,    seg_pkg::UP,    seg_pkg::SEG_B, seg_pkg::UP);
        add_edge(seg_pkg::SEG_C, seg_pkg::DOWN,  seg_pkg::RIGHT, seg_pkg::SEG_D, seg_pkg::DOWN);
        add_edge(seg_pkg::SEG_D, seg_pkg::RIGHT, seg_pkg::LEFT,  seg_pkg::SEG_C, seg_pkg::UP);
        add_edge(seg_pkg::SEG_D, seg_pkg::LEFT,  seg_pkg::RIGHT, seg_pkg::SEG_E, seg_pkg::UP);
        add_edge(seg_pkg::SEG_E, seg_pkg::UP,    seg_pkg::RIGHT, seg_pkg::SEG_G, seg_pkg::RIGHT);
        add_edge(seg_pkg::SEG_E, seg_pkg::UP,    seg_pkg::UP,    seg_pkg::SEG_F, seg_pkg::UP);
        add_edge(seg_pkg::SEG_E, seg_pkg::DOWN,  seg_pkg::LEFT,  seg_pkg::SEG_D, seg_pkg::RIGHT);
        add_edge(seg_pkg::SEG_F, seg_pkg::UP,    seg_pkg::RIGHT, seg_pkg::SEG_A, seg_pkg::RIGHT);
        add_edge(seg_pkg::SEG_F, seg_pkg::DOWN,  seg_pkg::LEFT,  seg_pkg::SEG_G, seg_pkg::RIGHT);
        add_edge(seg_pkg::SEG_G, seg_pkg::RIGHT, seg_pkg::LEFT,  seg_pkg::SEG_B, seg_pkg::UP);
        add_edge(seg_pkg::SEG_G, seg_pkg::RIGHT, seg_pkg::RIGHT, seg_pkg::SEG_C, seg_pkg::DOWN);
        add_edge(seg_pkg::SEG_G, seg_pkg::LEFT,  seg_pkg::LEFT,  seg_pkg::SEG_E, seg_pkg::DOWN);
        add_edge(seg_pkg::SEG_G, seg_pkg::LEFT,  seg_pkg::RIGHT, seg_pkg::SEG_F, seg_pkg::UP);
    endtask

    task automatic expect_eq(input string name, input logic [7:0] expected,
                             input logic [7:0] actual);
        assert (actual === expected) else begin
            errors++;
            $display("error %s expected %h got %h", name, expected, actual);
        end
    endtask

    task automatic step_clock(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_phase(input game_pkg::phase_t which, input int limit,
                              input string what);
        int n;
        n = 0;
        while (!phase_flag(which) && n < limit) begin
            step_clock(1);
            n++;
        end
        if (!phase_flag(which)) begin
            errors++;
            $display("timeout: no %s within %0d cycles", what, limit);
        end
    endtask

    task automatic set_button(input seg_pkg::dir_t btn, input logic level);
        case (btn)
            seg_pkg::RIGHT: right = level;
            seg_pkg::LEFT:  left  = level;
            seg_pkg::UP:    up    = level;
            default:        down  = level;
        endcase
    endtask

    // Hold, release, then move the model and compare once things settle
    task automatic press(input seg_pkg::dir_t btn, input int hold);
        logic [5:0] nxt;
        stepping = 1'b1;
        set_button(btn, 1'b1);
        step_clock(hold);
        set_button(btn, 1'b0);
        step_clock(HOLD);
        if (hold >= game_pkg::DEBOUNCE_DEPTH) begin
            if (btn == seg_pkg::DOWN) begin
                fall_model = 1'b1;
                visited    = lit_mask(model_seg);
            end else begin
                nxt = walk_tab[{model_seg, model_head, btn}];
                if (nxt[5]) begin
                    model_seg  = nxt[4:2];
                    model_head = seg_pkg::dir_t'(nxt[1:0]);
                    if (fall_model) begin
                        visited = visited | lit_mask(model_seg);
                    end
                end
            end
        end
        if (!fall_model) begin
            expect_eq("segments", dark_except(model_seg), segments);
            expect_eq("heading", model_head, heading);
        end else if (!(&visited)) begin
            // Fall holds until the last segment is reached
            expect_eq("fall", 8'h1, fall);
            expect_eq("heading", model_head, heading);
        end
        stepping = 1'b0;
    endtask

    function automatic seg_pkg::dir_t pick_button(input logic [31:0] r);
        case (r % 3)
            0:       return seg_pkg::RIGHT;
            1:       return seg_pkg::LEFT;
            default: return seg_pkg::UP;
        endcase
    endfunction

    // Trail and blink checks while no press is in flight
    always @(negedge clk) begin : fall_monitor
        int i;
        if (!rst && fall && fall_model && !stepping) begin
            for (i = 0; i < seg_pkg::NUM_SEGS; i++) begin
                if (i != int'(model_seg)) begin
                    assert (segments[i] === ~visited[i]) else begin
                        errors++;
                        $display("error segments[%0d] expected %h got %h",
                                 i, ~visited[i], segments[i]);
                    end
                end
            end
            // Blink flips on the edge right after each half tick
            if (quiet_prev && (cyc % TICK_CYCLES) != 1) begin
                assert (segments[model_seg] === cursor_bit_prev) else begin
                    errors++;
                    $display("error segments[%0d] expected %h got %h",
                             model_seg, cursor_bit_prev, segments[model_seg]);
                end
            end
            cursor_bit_prev = segments[model_seg];
            quiet_prev      = 1'b1;
        end else begin
            quiet_prev = 1'b0;
        end
    end

    flags_onehot_a: assert property (
        @(posedge clk) disable iff (rst)
        $onehot({init, move, fall})
    ) else begin
        errors++;
        $display("phase flags are not exactly one high: init %0b move %0b fall %0b",
                 init, move, fall);
    end

    init_shows_g_a: assert property (
        @(posedge clk) disable iff (rst)
        init |-> segments == G_ONLY
    ) else begin
        errors++;
        $display("error segments expected %h got %h", G_ONLY, $sampled(segments));
    end

    move_one_lit_a: assert property (
        @(posedge clk) disable iff (rst)
        move |-> $onehot(~segments)
    ) else begin
        errors++;
        $display("more or less than one segment lit during move");
    end

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        right      = 1'b0;
        left       = 1'b0;
        up         = 1'b0;
        down       = 1'b0;
        errors     = 0;
        rng        = 32'hfb6d_ed7a;
        stepping   = 1'b0;
        fall_model = 1'b0;
        quiet_prev = 1'b0;
        model_seg  = seg_pkg::SEG_G;
        model_head = seg_pkg::LEFT;
        visited    = '0;
        load_walk_table();
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        expect_eq("init", 8'h1, init);
        expect_eq("move", 8'h0, move);
        expect_eq("fall", 8'h0, fall);
        expect_eq("segments", G_ONLY, segments);
        expect_eq("heading", seg_pkg::LEFT, heading);

        wait_phase(game_pkg::PH_MOVE, MOVE_LIMIT, "move phase after reset");
        expect_eq("init", 8'h0, init);

        // Glitches shorter than the debounce window
        press(seg_pkg::RIGHT, SHORT);
        press(seg_pkg::LEFT, SHORT);
        press(seg_pkg::UP, SHORT);

        press(seg_pkg::DOWN, HOLD);
        expect_eq("fall", 8'h1, fall);
        expect_eq("move", 8'h0, move);
        step_clock(2 * TICK_CYCLES);

        // G E D C B A F, with a dead press first
        press(seg_pkg::UP, HOLD);
        press(seg_pkg::LEFT, HOLD);
        press(seg_pkg::LEFT, HOLD);
        press(seg_pkg::LEFT, HOLD);
        step_clock(TICK_CYCLES);
        press(seg_pkg::UP, HOLD);
        press(seg_pkg::LEFT, HOLD);
        press(seg_pkg::LEFT, HOLD);
        wait_phase(game_pkg::PH_INIT, 2 * TICK_CYCLES, "return to init after the trail filled");
        fall_model = 1'b0;
        model_seg  = seg_pkg::SEG_G;
        model_head = seg_pkg::LEFT;
        expect_eq("segments", G_ONLY, segments);
        expect_eq("heading", seg_pkg::LEFT, heading);

        wait_phase(game_pkg::PH_MOVE, MOVE_LIMIT, "move phase in the second game");
        repeat (NUM_PRESSES) begin
            rng = xorshift32(rng);
            press(pick_button(rng), HOLD);
        end

        $display("run finished with %0d errors", errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* filelist.f */
logic/seg_pkg.sv
logic/game_pkg.sv
logic/button_pulse.sv
logic/tick_gen.sv
logic/game_fsm.sv
logic/segment_walker.sv
logic/trail_display.sv
logic/snake_top.sv
tests/snake_tb.sv
